//--- source/ex_pkg.sv
/* integer execute path definitions */
`default_nettype none

package ex_pkg;

    parameter int xlen       = 64;
    parameter int reg_addr_w = 5;

    // one buffer entry holds the rd address above the data
    parameter int entry_w    = reg_addr_w + xlen;

    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_slt,
        op_sltu,
        op_xor,
        op_or,
        op_and,
        op_sll,
        op_srl,
        op_sra,
        op_addw,
        op_subw,
        op_sllw,
        op_srlw,
        op_sraw,
        op_lui,
        op_jal,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_bltu,
        op_bgeu,
        op_nop
    } op_t;

    function automatic logic op_is_branch(input op_t op);
        return op inside {op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu};
    endfunction

endpackage

`default_nettype wire

//--- source/ex_alu.sv
/* ALU and branch execute stage */
`default_nettype none

module ex_alu (
    input  wire logic                           clk_i,
    input  wire logic                           rst_n_i,
    input  wire logic                           issue_valid_i,
    input  wire ex_pkg::op_t                    op_i,
    input  wire logic [ex_pkg::xlen-1:0]        op1_i,
    input  wire logic [ex_pkg::xlen-1:0]        op2_i,
    input  wire logic [ex_pkg::xlen-1:0]        pc_i,
    input  wire logic [ex_pkg::xlen-1:0]        offset_i,
    input  wire logic [ex_pkg::reg_addr_w-1:0]  rd_addr_i,
    output logic                                push_o,
    output logic [ex_pkg::reg_addr_w-1:0]       push_rd_o,
    output logic [ex_pkg::xlen-1:0]             push_data_o,
    output logic                                branch_valid_o,
    output logic                                branch_taken_o,
    output logic [ex_pkg::xlen-1:0]             branch_pc_o
);

    import ex_pkg::*;

    logic [xlen-1:0] alu_res;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] pc_target;
    logic [31:0]     addw_res;
    logic [31:0]     subw_res;
    logic [31:0]     sllw_res;
    logic [31:0]     srlw_res;
    logic [31:0]     sraw_res;
    logic            lt_signed;
    logic            lt_unsigned;
    logic            is_equal;
    logic            is_branch;
    logic            taken;
    logic            writes_rd;

    function automatic logic [xlen-1:0] sext_word(input logic [31:0] w);
        return {{(xlen-32){w[31]}}, w};
    endfunction

    assign pc_plus4  = pc_i + 64'd4;
    assign pc_target = pc_i + offset_i;

    // word ops only look at the low halves
    assign addw_res = op1_i[31:0] + op2_i[31:0];
    assign subw_res = op1_i[31:0] - op2_i[31:0];
    assign sllw_res = op1_i[31:0] << op2_i[4:0];
    assign srlw_res = op1_i[31:0] >> op2_i[4:0];
    assign sraw_res = $signed(op1_i[31:0]) >>> op2_i[4:0];

    assign lt_signed   = $signed(op1_i) < $signed(op2_i);
    assign lt_unsigned = op1_i < op2_i;
    assign is_equal    = op1_i == op2_i;

    always_comb begin
        case (op_i)
            op_add:  alu_res = op1_i + op2_i;
            op_sub:  alu_res = op1_i - op2_i;
            op_slt:  alu_res = {{(xlen-1){1'b0}}, lt_signed};
            op_sltu: alu_res = {{(xlen-1){1'b0}}, lt_unsigned};
            op_xor:  alu_res = op1_i ^ op2_i;
            op_or:   alu_res = op1_i | op2_i;
            op_and:  alu_res = op1_i & op2_i;
            op_sll:  alu_res = op1_i << op2_i[5:0];
            op_srl:  alu_res = op1_i >> op2_i[5:0];
            op_sra:  alu_res = $signed(op1_i) >>> op2_i[5:0];
            op_addw: alu_res = sext_word(addw_res);
            op_subw: alu_res = sext_word(subw_res);
            op_sllw: alu_res = sext_word(sllw_res);
            op_srlw: alu_res = sext_word(srlw_res);
            op_sraw: alu_res = sext_word(sraw_res);
            // 20-bit upper immediate
            op_lui:  alu_res = sext_word({op2_i[19:0], 12'd0});
            // link address
            op_jal:  alu_res = pc_plus4;
            default: alu_res = '0;
        endcase
    end

    always_comb begin
        case (op_i)
            op_beq:  taken = is_equal;
            op_bne:  taken = !is_equal;
            op_blt:  taken = lt_signed;
            op_bge:  taken = !lt_signed;
            op_bltu: taken = lt_unsigned;
            op_bgeu: taken = !lt_unsigned;
            default: taken = 1'b0;
        endcase
    end

    assign is_branch = op_is_branch(op_i);

    // x0 writes and nops never reach the buffer
    assign writes_rd = !is_branch && (op_i != op_nop) && (rd_addr_i != '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            push_o         <= 1'b0;
            branch_valid_o <= 1'b0;
            branch_taken_o <= 1'b0;
        end else begin
            push_o         <= issue_valid_i && writes_rd;
            branch_valid_o <= issue_valid_i && is_branch;
            branch_taken_o <= issue_valid_i && is_branch && taken;
        end
    end

    always_ff @(posedge clk_i) begin
        if (issue_valid_i) begin
            push_rd_o   <= rd_addr_i;
            push_data_o <= alu_res;
            branch_pc_o <= taken ? pc_target : pc_plus4;
        end
    end

endmodule

`default_nettype wire

//--- source/wb_fifo.sv
/* write-back result FIFO */
`default_nettype none

module wb_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                           clk_i,
    input  wire logic                           rst_n_i,
    input  wire logic                           push_i,
    input  wire logic [ex_pkg::reg_addr_w-1:0]  push_rd_i,
    input  wire logic [ex_pkg::xlen-1:0]        push_data_i,
    input  wire logic                           pop_i,
    output logic [ex_pkg::reg_addr_w-1:0]       head_rd_o,
    output logic [ex_pkg::xlen-1:0]             head_data_o,
    output logic                                empty_o,
    output logic                                afull_o
);

    import ex_pkg::*;

    localparam int ptr_w = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int cnt_w = $clog2(FIFO_DEPTH + 1);

    logic [entry_w-1:0] mem [FIFO_DEPTH];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [cnt_w-1:0]   count;
    logic               full;
    logic               do_push;
    logic               do_pop;

    assign full    = count == cnt_w'(FIFO_DEPTH);
    assign empty_o = count == '0;
    // one slot kept free for the result still in the ALU register
    assign afull_o = count >= cnt_w'(FIFO_DEPTH - 1);

    assign do_push = push_i && !full;
    assign do_pop  = pop_i && !empty_o;

    assign {head_rd_o, head_data_o} = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == ptr_w'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + cnt_w'(do_push) - cnt_w'(do_pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= {push_rd_i, push_data_i};
        end
    end

endmodule

`default_nettype wire

//--- source/reg_writeback.sv
/* register write-back and file */
`default_nettype none

module reg_writeback (
    input  wire logic                           clk_i,
    input  wire logic                           rst_n_i,
    input  wire logic                           wb_enable_i,
    input  wire logic                           fifo_empty_i,
    input  wire logic [ex_pkg::reg_addr_w-1:0]  head_rd_i,
    input  wire logic [ex_pkg::xlen-1:0]        head_data_i,
    input  wire logic [ex_pkg::reg_addr_w-1:0]  rf_raddr_i,
    output logic                                pop_o,
    output logic [ex_pkg::xlen-1:0]             rf_rdata_o
);

    import ex_pkg::*;

    // x1..x31, x0 is not stored
    logic [xlen-1:0] regs [1:31];

    assign pop_o = wb_enable_i && !fifo_empty_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (pop_o && (head_rd_i != '0)) begin
            regs[head_rd_i] <= head_data_i;
        end
    end

    // async read, x0 hardwired
    always_comb begin
        if (rf_raddr_i == '0) begin
            rf_rdata_o = '0;
        end else begin
            rf_rdata_o = regs[rf_raddr_i];
        end
    end

endmodule

`default_nettype wire

//--- source/ex_top.sv
/* execute path top level */
`default_nettype none

module ex_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                           clk_i,
    input  wire logic                           rst_n_i,
    input  wire logic                           issue_valid_i,
    input  wire ex_pkg::op_t                    op_i,
    input  wire logic [ex_pkg::xlen-1:0]        op1_i,
    input  wire logic [ex_pkg::xlen-1:0]        op2_i,
    input  wire logic [ex_pkg::xlen-1:0]        pc_i,
    input  wire logic [ex_pkg::xlen-1:0]        offset_i,
    input  wire logic [ex_pkg::reg_addr_w-1:0]  rd_addr_i,
    input  wire logic                           wb_enable_i,
    input  wire logic [ex_pkg::reg_addr_w-1:0]  rf_raddr_i,
    output logic                                ex_stall_o,
    output logic                                branch_valid_o,
    output logic                                branch_taken_o,
    output logic [ex_pkg::xlen-1:0]             branch_pc_o,
    output logic [ex_pkg::xlen-1:0]             rf_rdata_o
);

    import ex_pkg::*;

    logic                  push;
    logic [reg_addr_w-1:0] push_rd;
    logic [xlen-1:0]       push_data;
    logic [reg_addr_w-1:0] head_rd;
    logic [xlen-1:0]       head_data;
    logic                  fifo_empty;
    logic                  pop;

    ex_alu ex_alu_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .issue_valid_i  (issue_valid_i),
        .op_i           (op_i),
        .op1_i          (op1_i),
        .op2_i          (op2_i),
        .pc_i           (pc_i),
        .offset_i       (offset_i),
        .rd_addr_i      (rd_addr_i),
        .push_o         (push),
        .push_rd_o      (push_rd),
        .push_data_o    (push_data),
        .branch_valid_o (branch_valid_o),
        .branch_taken_o (branch_taken_o),
        .branch_pc_o    (branch_pc_o)
    );

    // afull doubles as the issue stall
    wb_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) wb_fifo_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .push_i      (push),
        .push_rd_i   (push_rd),
        .push_data_i (push_data),
        .pop_i       (pop),
        .head_rd_o   (head_rd),
        .head_data_o (head_data),
        .empty_o     (fifo_empty),
        .afull_o     (ex_stall_o)
    );

    reg_writeback reg_writeback_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .wb_enable_i  (wb_enable_i),
        .fifo_empty_i (fifo_empty),
        .head_rd_i    (head_rd),
        .head_data_i  (head_data),
        .rf_raddr_i   (rf_raddr_i),
        .pop_o        (pop),
        .rf_rdata_o   (rf_rdata_o)
    );

endmodule

`default_nettype wire

//--- dv/tb_ex_top.sv
/* execute path testbench */
`default_nettype none

module tb_ex_top;

    import ex_pkg::*;

    localparam int mode_rand  = 0;
    localparam int mode_hold  = 1;
    localparam int mode_drain = 2;
    localparam int wait_limit = 200;

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  issue_valid_i;
    op_t                   op_i;
    logic [xlen-1:0]       op1_i;
    logic [xlen-1:0]       op2_i;
    logic [xlen-1:0]       pc_i;
    logic [xlen-1:0]       offset_i;
    logic [reg_addr_w-1:0] rd_addr_i;
    logic                  wb_enable_i;
    logic [reg_addr_w-1:0] rf_raddr_i;
    logic                  ex_stall_o;
    logic                  branch_valid_o;
    logic                  branch_taken_o;
    logic [xlen-1:0]       branch_pc_o;
    logic [xlen-1:0]       rf_rdata_o;

    // fields of the current stim line
    int                    fd;
    int                    n;
    string                 kind;
    string                 rest;
    string                 op_name;
    op_t                   stim_op;
    logic [xlen-1:0]       stim_op1;
    logic [xlen-1:0]       stim_op2;
    logic [xlen-1:0]       stim_pc;
    logic [xlen-1:0]       stim_off;
    logic [xlen-1:0]       stim_val;
    logic [reg_addr_w-1:0] stim_rd;
    logic                  stim_taken;
    int                    wb_mode;
    logic                  stall_seen;
    logic [15:0]           lfsr;

    ex_top ex_top_inst (.*);

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] actual,
                               input logic [xlen-1:0] expected);
        if (actual !== expected) begin
            fail_run($sformatf("ERR %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    // fibonacci, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic lookup_op(input string name, output op_t op);
        op_t cand;
        op   = op_nop;
        cand = cand.first();
        for (int i = 0; i < cand.num(); i++) begin
            if (cand.name() == name) begin
                op = cand;
                return;
            end
            cand = cand.next();
        end
        fail_run({"unknown op in stim file: ", name});
    endtask

    task automatic issue_instr();
        logic            br_op;
        logic [xlen-1:0] exp_pc;
        int              waited;
        br_op  = op_name.substr(0, 3) == "op_b";
        exp_pc = stim_taken ? stim_pc + stim_off : stim_pc + 64'd4;
        waited = 0;
        while (ex_stall_o) begin
            // held write-back is let go once the buffer pushes back
            if (wb_mode == mode_hold) begin
                stall_seen = 1'b1;
                wb_mode    = mode_rand;
            end
            @(negedge clk_i);
            waited++;
            if (waited > wait_limit) begin
                fail_run("timeout while ex_stall_o stayed high");
            end
        end
        @(posedge clk_i);
        issue_valid_i <= 1'b1;
        op_i          <= stim_op;
        op1_i         <= stim_op1;
        op2_i         <= stim_op2;
        pc_i          <= stim_pc;
        offset_i      <= stim_off;
        rd_addr_i     <= stim_rd;
        @(posedge clk_i);
        issue_valid_i <= 1'b0;
        @(negedge clk_i);
        check_value("branch_valid_o", 64'(branch_valid_o), 64'(br_op));
        if (br_op) begin
            check_value("branch_taken_o", 64'(branch_taken_o), 64'(stim_taken));
            check_value("branch_pc_o", branch_pc_o, exp_pc);
            check_value("stim target column", stim_val, exp_pc);
        end
        @(negedge clk_i);
        check_value("branch_valid_o", 64'(branch_valid_o), 64'd0);
    endtask

    task automatic read_check();
        int waited;
        waited  = 0;
        wb_mode = mode_drain;
        while (!ex_top_inst.fifo_empty) begin
            @(negedge clk_i);
            waited++;
            if (waited > wait_limit) begin
                fail_run("timeout while draining the result FIFO");
            end
        end
        @(posedge clk_i);
        rf_raddr_i <= stim_rd;
        @(negedge clk_i);
        check_value($sformatf("rf_rdata_o x%0d", stim_rd), rf_rdata_o, stim_val);
        wb_mode = mode_rand;
    endtask

    initial begin
        clk_i = 1'b0;
        forever begin
            #4 clk_i = ~clk_i;
        end
    end

    // write-back enable, random unless held or draining
    initial begin
        lfsr = 16'd5;
        wb_enable_i <= 1'b0;
        forever begin
            @(posedge clk_i);
            if (wb_mode == mode_hold) begin
                wb_enable_i <= 1'b0;
            end else if (wb_mode == mode_drain) begin
                wb_enable_i <= 1'b1;
            end else begin
                lfsr = lfsr_step(lfsr);
                wb_enable_i <= lfsr[0];
            end
        end
    end

    initial begin
        wb_mode       = mode_rand;
        stall_seen    = 1'b0;
        rst_n_i       <= 1'b0;
        issue_valid_i <= 1'b0;
        op_i          <= op_nop;
        op1_i         <= '0;
        op2_i         <= '0;
        pc_i          <= '0;
        offset_i      <= '0;
        rd_addr_i     <= '0;
        rf_raddr_i    <= '0;
        fd = $fopen("dv/ex_stim.txt", "r");
        if (fd == 0) begin
            fail_run("cannot open dv/ex_stim.txt");
        end
        repeat (10) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(negedge clk_i);
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "#") begin
                n = $fgets(rest, fd);
            end else if (kind == "I") begin
                n = $fscanf(fd, "%s %h %h %d %h %h %d %h", op_name, stim_op1, stim_op2,
                            stim_rd, stim_pc, stim_off, stim_taken, stim_val);
                if (n != 8) begin
                    fail_run("incomplete issue line in stim file");
                end
                lookup_op(op_name, stim_op);
                issue_instr();
            end else if (kind == "R") begin
                n = $fscanf(fd, "%d %h", stim_rd, stim_val);
                if (n != 2) begin
                    fail_run("incomplete read line in stim file");
                end
                read_check();
            end else if (kind == "H") begin
                wb_mode    = mode_hold;
                stall_seen = 1'b0;
            end else if (kind == "G") begin
                if (!stall_seen) begin
                    fail_run("ex_stall_o never rose while write-back was held");
                end
                wb_mode = mode_rand;
            end else begin
                fail_run({"unknown line kind in stim file: ", kind});
            end
        end
        $fclose(fd);
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
source/ex_pkg.sv
source/ex_alu.sv
source/wb_fifo.sv
source/reg_writeback.sv
source/ex_top.sv
dv/tb_ex_top.sv

//--- run.sh
#!/bin/bash
# build the execute path testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
log=sim.log
rm -f "$log"
verilator --binary --timing -f all.f --top-module tb_ex_top -o tb_ex_top > "$log" 2>&1 \
    && ./obj_dir/tb_ex_top >> "$log" 2>&1 \
    || echo "Test failures found" >> "$log"
cat "$log"
grep -q "Test failures found" "$log" && exit 1 || exit 0

//--- dv/ex_stim.txt
# I op op1 op2 rd pc offset taken target | R rd value | H hold write-back | G resume it
# op1 op2 pc offset target value in hex, rd and taken in decimal
I op_add  5 7 1 0 0 0 0
I op_sub  3 5 2 0 0 0 0
I op_slt  fffffffffffffffe 1 3 0 0 0 0
I op_sltu fffffffffffffffe 1 4 0 0 0 0
I op_xor  f0f0 ff00 5 0 0 0 0
I op_or   f0f0 ff00 6 0 0 0 0
I op_and  f0f0 ff00 7 0 0 0 0
I op_sll  1 3f 8 0 0 0 0
I op_srl  8000000000000000 3f 9 0 0 0 0
I op_sra  8000000000000000 3c 10 0 0 0 0
I op_lui  0 80000 11 0 0 0 0
I op_jal  0 0 12 1000 0 0 0
I op_addw 7fffffff 1 13 0 0 0 0
I op_subw 0 1 14 0 0 0 0
I op_sraw 80000000 4 15 0 0 0 0
I op_add  5 7 0 0 0 0 0
R 1 c
R 2 fffffffffffffffe
R 3 1
R 4 0
R 5 ff0
R 6 fff0
R 7 f000
R 8 8000000000000000
R 9 1
R 10 fffffffffffffff8
R 11 ffffffff80000000
R 12 1004
R 13 ffffffff80000000
R 14 ffffffffffffffff
R 15 fffffffff8000000
R 0 0
I op_beq  5 5 0 2000 10 1 2010
I op_bne  5 5 0 2000 10 0 2004
I op_blt  fffffffffffffffe 1 0 3000 fffffffffffffff0 1 2ff0
I op_bge  fffffffffffffffe 1 0 3000 fffffffffffffff0 0 3004
I op_bltu fffffffffffffffe 1 0 4000 8 0 4004
I op_bgeu fffffffffffffffe 1 0 4000 8 1 4008
H
I op_add  1 0 20 0 0 0 0
I op_add  2 0 21 0 0 0 0
I op_add  3 0 20 0 0 0 0
I op_add  4 0 22 0 0 0 0
I op_add  5 0 20 0 0 0 0
G
R 20 5
R 21 2
R 22 4
